/* rtl/memBus_cfg.svh */
`ifndef MEMBUS_CFG_SVH
`define MEMBUS_CFG_SVH

// byte address width on the bus
`define MEM_ADDR_W 48

// one bus transfer is a whole line
`define MEM_DATA_W 128

// line RAM depth, address is the line index times 16
`define MEM_RAM_LINES 256

// lines below this index refuse stores
`define MEM_RO_LINES 16

// cycles from a new request to the answer
`define MEM_RAM_LATENCY 3

`endif

/* rtl/memBusPkg.sv */
package memBusPkg;

	// opcode held by a bus master for the whole transaction
	typedef enum logic [4:0]
	{
		MEM_OPM_READY = 5'h00,
		MEM_OPM_LOAD  = 5'h01,
		MEM_OPM_STORE = 5'h02
	} memOpm_t;

	// slave answer
	typedef enum logic [1:0]
	{
		MEM_OK_READY = 2'b00,
		MEM_OK_OK    = 2'b01,
		MEM_OK_HOLD  = 2'b10,
		MEM_OK_FAULT = 2'b11
	} memOk_t;

	// bus exception word
	// 63:16 address, 15 valid, 11:8 target, 7:0 code
	typedef logic [63:0] memExc_t;

	localparam int MEM_EXC_VALID = 15;

	// target field values
	localparam logic [3:0] MEM_TGT_PORT2 = 4'h2;
	localparam logic [3:0] MEM_TGT_ALL   = 4'hF;

	// exception codes
	localparam logic [7:0] MEM_EXC_RANGE  = 8'h01;
	localparam logic [7:0] MEM_EXC_RDONLY = 8'h02;

endpackage

/* rtl/memBusJoin.sv */
`timescale 1ns/1ps
`include "memBus_cfg.svh"

module memBusJoin
(
	input  logic                   clock_cpu,
	input  logic                   reset,

	output memBusPkg::memOpm_t     memOpm,
	output logic [`MEM_ADDR_W-1:0] memAddr,
	output logic [`MEM_DATA_W-1:0] memOutData,
	input  logic [`MEM_DATA_W-1:0] memInData,
	input  memBusPkg::memOk_t      memOk,
	input  memBusPkg::memExc_t     memBusExc,

	input  memBusPkg::memOpm_t     mem1Opm,
	input  logic [`MEM_ADDR_W-1:0] mem1Addr,
	input  logic [`MEM_DATA_W-1:0] mem1OutData,
	output logic [`MEM_DATA_W-1:0] mem1InData,
	output memBusPkg::memOk_t      mem1Ok,
	output memBusPkg::memExc_t     mem1BusExc,

	input  memBusPkg::memOpm_t     mem2Opm,
	input  logic [`MEM_ADDR_W-1:0] mem2Addr,
	input  logic [`MEM_DATA_W-1:0] mem2OutData,
	output logic [`MEM_DATA_W-1:0] mem2InData,
	output memBusPkg::memOk_t      mem2Ok,
	output memBusPkg::memExc_t     mem2BusExc
);

	import memBusPkg::*;

	// answer from the RAM, registered once
	memOk_t                 tMemOk;
	logic [`MEM_DATA_W-1:0] tMemInData;
	memExc_t                tMemBusExc;

	// ownership of the shared bus
	logic tMem1Latch;
	logic tMem2Latch;
	logic tNextMem1Latch;
	logic tNextMem2Latch;
	logic tMemStrobe;

	// request of the current owner, before the register stage
	memOpm_t                fwdOpm;
	logic [`MEM_ADDR_W-1:0] fwdAddr;
	logic [`MEM_DATA_W-1:0] fwdData;

	logic [3:0] excTarget;

	always_comb
	begin
		tNextMem1Latch = tMem1Latch;
		tNextMem2Latch = tMem2Latch;
		fwdOpm         = MEM_OPM_READY;
		fwdAddr        = mem1Addr;
		fwdData        = mem1OutData;

		if (tMem1Latch)
		begin
			// hold until the master is back at READY and the RAM agrees
			tNextMem1Latch = (mem1Opm != MEM_OPM_READY) || (tMemOk != MEM_OK_READY);
			fwdOpm         = mem1Opm;
		end
		else if (tMem2Latch)
		begin
			tNextMem2Latch = (mem2Opm != MEM_OPM_READY) || (tMemOk != MEM_OK_READY);
			fwdOpm         = mem2Opm;
			fwdAddr        = mem2Addr;
			fwdData        = mem2OutData;
		end
		else if ((mem1Opm != MEM_OPM_READY) &&
			!((mem2Opm != MEM_OPM_READY) && tMemStrobe))
		begin
			tNextMem1Latch = 1'b1;
		end
		else if (mem2Opm != MEM_OPM_READY)
		begin
			tNextMem2Latch = 1'b1;
		end
	end

	// only the owner sees the RAM answer, the other port waits on READY
	always_comb
	begin
		mem1Ok = MEM_OK_READY;
		mem2Ok = MEM_OK_READY;
		if (tMem1Latch)
			mem1Ok = tMemOk;
		if (tMem2Latch)
			mem2Ok = tMemOk;
	end

	assign mem1InData = tMemInData;
	assign mem2InData = tMemInData;

	// port 1 always gets the exception word
	assign excTarget  = tMemBusExc[11:8];
	assign mem1BusExc = tMemBusExc;
	assign mem2BusExc = (tMemBusExc[MEM_EXC_VALID] &&
		((excTarget == MEM_TGT_PORT2) || (excTarget == MEM_TGT_ALL))) ? tMemBusExc : '0;

	always_ff @(posedge clock_cpu)
	begin
		if (reset)
		begin
			tMem1Latch <= 1'b0;
			tMem2Latch <= 1'b0;
			tMemStrobe <= 1'b0;
			memOpm     <= MEM_OPM_READY;
			tMemOk     <= MEM_OK_READY;
			tMemBusExc <= '0;
		end
		else
		begin
			tMem1Latch <= tNextMem1Latch;
			tMem2Latch <= tNextMem2Latch;
			tMemStrobe <= !tMemStrobe;
			memOpm     <= fwdOpm;
			tMemOk     <= memOk;
			tMemBusExc <= memBusExc;
		end
	end

	always_ff @(posedge clock_cpu)
	begin
		memAddr    <= fwdAddr;
		memOutData <= fwdData;
		tMemInData <= memInData;
	end

endmodule

/* rtl/memRequester.sv */
`timescale 1ns/1ps
`include "memBus_cfg.svh"

module memRequester
(
	input  logic                   clock_cpu,
	input  logic                   reset,

	input  logic                   req,
	input  logic                   isStore,
	input  logic [`MEM_ADDR_W-1:0] addr,
	input  logic [`MEM_DATA_W-1:0] wdata,
	output logic                   done,
	output logic [`MEM_DATA_W-1:0] rdata,
	output logic                   fault,
	output memBusPkg::memExc_t     lastExc,

	output memBusPkg::memOpm_t     memOpm,
	output logic [`MEM_ADDR_W-1:0] memAddr,
	output logic [`MEM_DATA_W-1:0] memOutData,
	input  logic [`MEM_DATA_W-1:0] memInData,
	input  memBusPkg::memOk_t      memOk,
	input  memBusPkg::memExc_t     memBusExc
);

	import memBusPkg::*;

	typedef enum logic [1:0]
	{
		ST_IDLE,
		ST_REQ,
		ST_REL
	} reqState_t;

	reqState_t state;
	logic      answered;

	// slave finished, either way
	assign answered = (memOk == MEM_OK_OK) || (memOk == MEM_OK_FAULT);

	always_ff @(posedge clock_cpu)
	begin
		if (reset)
		begin
			state   <= ST_IDLE;
			memOpm  <= MEM_OPM_READY;
			done    <= 1'b0;
			fault   <= 1'b0;
			lastExc <= '0;
		end
		else
		begin
			done <= 1'b0;

			// any valid exception the join hands us, ours or not
			if (memBusExc[MEM_EXC_VALID])
				lastExc <= memBusExc;

			case (state)
				ST_IDLE:
				begin
					if (req)
					begin
						if (isStore)
							memOpm <= MEM_OPM_STORE;
						else
							memOpm <= MEM_OPM_LOAD;
						state <= ST_REQ;
					end
				end
				ST_REQ:
				begin
					if (answered)
					begin
						fault  <= (memOk == MEM_OK_FAULT);
						memOpm <= MEM_OPM_READY;
						state  <= ST_REL;
					end
				end
				ST_REL:
				begin
					// transaction over once the bus reads READY again
					if (memOk == MEM_OK_READY)
					begin
						done  <= 1'b1;
						state <= ST_IDLE;
					end
				end
				default:
				begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// request payload and returned line
	always_ff @(posedge clock_cpu)
	begin
		if ((state == ST_IDLE) && req)
		begin
			memAddr    <= addr;
			memOutData <= wdata;
		end
		if ((state == ST_REQ) && (memOk == MEM_OK_OK) && (memOpm == MEM_OPM_LOAD))
			rdata <= memInData;
	end

endmodule

/* rtl/memLineRam.sv */
`timescale 1ns/1ps
`include "memBus_cfg.svh"

module memLineRam
(
	input  logic                   clock_cpu,
	input  logic                   reset,

	input  memBusPkg::memOpm_t     memOpm,
	input  logic [`MEM_ADDR_W-1:0] memAddr,
	input  logic [`MEM_DATA_W-1:0] memOutData,
	output logic [`MEM_DATA_W-1:0] memInData,
	output memBusPkg::memOk_t      memOk,
	output memBusPkg::memExc_t     memBusExc
);

	import memBusPkg::*;

	localparam int LINE_W = $clog2(`MEM_RAM_LINES);
	localparam int OFS_W  = $clog2(`MEM_DATA_W / 8);
	localparam int CNT_W  = $clog2(`MEM_RAM_LATENCY + 1);

	logic [`MEM_DATA_W-1:0] lines [`MEM_RAM_LINES];

	logic                         busy;
	logic [CNT_W-1:0]             cnt;
	logic [`MEM_ADDR_W-OFS_W-1:0] lineIdx;
	logic                         outOfRange;
	logic                         readOnly;
	logic [3:0]                   excTarget;
	logic [7:0]                   excCode;

	assign lineIdx    = memAddr[`MEM_ADDR_W-1:OFS_W];
	assign outOfRange = lineIdx >= `MEM_RAM_LINES;
	assign readOnly   = (memOpm == MEM_OPM_STORE) && (lineIdx < `MEM_RO_LINES);

	// range fault goes to both ports, read-only only to port 2
	assign excTarget = outOfRange ? MEM_TGT_ALL : MEM_TGT_PORT2;
	assign excCode   = outOfRange ? MEM_EXC_RANGE : MEM_EXC_RDONLY;

	always_ff @(posedge clock_cpu)
	begin
		if (reset)
		begin
			memOk     <= MEM_OK_READY;
			memBusExc <= '0;
			busy      <= 1'b0;
			cnt       <= '0;
			// each line holds its own index, repeated
			for (int i = 0; i < `MEM_RAM_LINES; i++)
				lines[i] <= {(`MEM_DATA_W / LINE_W){LINE_W'(i)}};
		end
		else if (memOpm == MEM_OPM_READY)
		begin
			memOk     <= MEM_OK_READY;
			memBusExc <= '0;
			busy      <= 1'b0;
		end
		else if (!busy)
		begin
			// new request; latencies below 2 behave as 2
			busy  <= 1'b1;
			cnt   <= CNT_W'(`MEM_RAM_LATENCY - 1);
			memOk <= MEM_OK_HOLD;
		end
		else if (memOk == MEM_OK_HOLD)
		begin
			if (cnt > 1)
				cnt <= cnt - 1'b1;
			else if (outOfRange || readOnly)
			begin
				memOk     <= MEM_OK_FAULT;
				memBusExc <= {memAddr, 1'b1, 3'b000, excTarget, excCode};
			end
			else
			begin
				memOk <= MEM_OK_OK;
				if (memOpm == MEM_OPM_STORE)
					lines[lineIdx[LINE_W-1:0]] <= memOutData;
				else
					memInData <= lines[lineIdx[LINE_W-1:0]];
			end
		end
	end

endmodule

/* rtl/memSubsystem.sv */
`timescale 1ns/1ps
`include "memBus_cfg.svh"

module memSubsystem
(
	input  logic                   clock_cpu,
	input  logic                   reset,

	input  logic                   fetchReq,
	input  logic [`MEM_ADDR_W-1:0] fetchAddr,
	output logic                   fetchDone,
	output logic [`MEM_DATA_W-1:0] fetchData,
	output logic                   fetchFault,
	output memBusPkg::memExc_t     fetchExc,

	input  logic                   dataReq,
	input  logic                   dataStore,
	input  logic [`MEM_ADDR_W-1:0] dataAddr,
	input  logic [`MEM_DATA_W-1:0] dataWData,
	output logic                   dataDone,
	output logic [`MEM_DATA_W-1:0] dataRData,
	output logic                   dataFault,
	output memBusPkg::memExc_t     dataExc
);

	import memBusPkg::*;

	// data port on join port 1
	memOpm_t                dataBusOpm;
	logic [`MEM_ADDR_W-1:0] dataBusAddr;
	logic [`MEM_DATA_W-1:0] dataBusOut;
	logic [`MEM_DATA_W-1:0] dataBusIn;
	memOk_t                 dataBusOk;
	memExc_t                dataBusExc;

	// fetch port on join port 2
	memOpm_t                fetchBusOpm;
	logic [`MEM_ADDR_W-1:0] fetchBusAddr;
	logic [`MEM_DATA_W-1:0] fetchBusOut;
	logic [`MEM_DATA_W-1:0] fetchBusIn;
	memOk_t                 fetchBusOk;
	memExc_t                fetchBusExc;

	// shared bus to the RAM
	memOpm_t                ramOpm;
	logic [`MEM_ADDR_W-1:0] ramAddr;
	logic [`MEM_DATA_W-1:0] ramOutData;
	logic [`MEM_DATA_W-1:0] ramInData;
	memOk_t                 ramOk;
	memExc_t                ramBusExc;

	memRequester dataPort_i
	(
		.clock_cpu  (clock_cpu),
		.reset      (reset),
		.req        (dataReq),
		.isStore    (dataStore),
		.addr       (dataAddr),
		.wdata      (dataWData),
		.done       (dataDone),
		.rdata      (dataRData),
		.fault      (dataFault),
		.lastExc    (dataExc),
		.memOpm     (dataBusOpm),
		.memAddr    (dataBusAddr),
		.memOutData (dataBusOut),
		.memInData  (dataBusIn),
		.memOk      (dataBusOk),
		.memBusExc  (dataBusExc)
	);

	// fetch only ever loads
	memRequester fetchPort_i
	(
		.clock_cpu  (clock_cpu),
		.reset      (reset),
		.req        (fetchReq),
		.isStore    (1'b0),
		.addr       (fetchAddr),
		.wdata      ('0),
		.done       (fetchDone),
		.rdata      (fetchData),
		.fault      (fetchFault),
		.lastExc    (fetchExc),
		.memOpm     (fetchBusOpm),
		.memAddr    (fetchBusAddr),
		.memOutData (fetchBusOut),
		.memInData  (fetchBusIn),
		.memOk      (fetchBusOk),
		.memBusExc  (fetchBusExc)
	);

	memBusJoin join_i
	(
		.clock_cpu   (clock_cpu),
		.reset       (reset),
		.memOpm      (ramOpm),
		.memAddr     (ramAddr),
		.memOutData  (ramOutData),
		.memInData   (ramInData),
		.memOk       (ramOk),
		.memBusExc   (ramBusExc),
		.mem1Opm     (dataBusOpm),
		.mem1Addr    (dataBusAddr),
		.mem1OutData (dataBusOut),
		.mem1InData  (dataBusIn),
		.mem1Ok      (dataBusOk),
		.mem1BusExc  (dataBusExc),
		.mem2Opm     (fetchBusOpm),
		.mem2Addr    (fetchBusAddr),
		.mem2OutData (fetchBusOut),
		.mem2InData  (fetchBusIn),
		.mem2Ok      (fetchBusOk),
		.mem2BusExc  (fetchBusExc)
	);

	memLineRam ram_i
	(
		.clock_cpu  (clock_cpu),
		.reset      (reset),
		.memOpm     (ramOpm),
		.memAddr    (ramAddr),
		.memOutData (ramOutData),
		.memInData  (ramInData),
		.memOk      (ramOk),
		.memBusExc  (ramBusExc)
	);

endmodule

/* sim/memSubsystemModel.svh */
`ifndef MEM_SUBSYSTEM_MODEL_SVH
`define MEM_SUBSYSTEM_MODEL_SVH

// shadow copy of the RAM lines
logic [`MEM_DATA_W-1:0] shadowMem [`MEM_RAM_LINES];

// exception word each port should be showing
logic [63:0] expDataExc;
logic [63:0] expFetchExc;

// reset contents, every byte of a line is the line index
function automatic void resetShadow();
	for (int i = 0; i < `MEM_RAM_LINES; i++)
		shadowMem[i] = {(`MEM_DATA_W / 8){8'(i)}};
	expDataExc  = '0;
	expFetchExc = '0;
endfunction

function automatic logic [`MEM_ADDR_W-5:0] lineOf(input logic [`MEM_ADDR_W-1:0] addr);
	return addr[`MEM_ADDR_W-1:4];
endfunction

// zero when the request succeeds
function automatic logic [7:0] faultCodeFor(input logic [`MEM_ADDR_W-1:0] addr,
	input logic store);
	if (lineOf(addr) >= `MEM_RAM_LINES)
		return 8'h01;
	if (store && (lineOf(addr) < `MEM_RO_LINES))
		return 8'h02;
	return 8'h00;
endfunction

// range faults are broadcast, read-only faults go to port 2
function automatic logic [63:0] excWordFor(input logic [`MEM_ADDR_W-1:0] addr,
	input logic [7:0] code);
	logic [63:0] word;
	word        = '0;
	word[63:16] = addr;
	word[15]    = 1'b1;
	word[11:8]  = (code == 8'h01) ? 4'hF : 4'h2;
	word[7:0]   = code;
	return word;
endfunction

// port 1 sees every exception, port 2 only its own target and broadcasts
function automatic void recordFault(input logic [63:0] word);
	expDataExc = word;
	if (word[15] && ((word[11:8] == 4'h2) || (word[11:8] == 4'hF)))
		expFetchExc = word;
endfunction

function automatic void storeLine(input logic [`MEM_ADDR_W-1:0] addr,
	input logic [`MEM_DATA_W-1:0] data);
	logic [`MEM_ADDR_W-5:0] line;
	line = lineOf(addr);
	shadowMem[line[$clog2(`MEM_RAM_LINES)-1:0]] = data;
endfunction

function automatic logic [`MEM_DATA_W-1:0] loadLine(input logic [`MEM_ADDR_W-1:0] addr);
	logic [`MEM_ADDR_W-5:0] line;
	line = lineOf(addr);
	return shadowMem[line[$clog2(`MEM_RAM_LINES)-1:0]];
endfunction

`endif

/* sim/tb_memSubsystem.sv */
`timescale 1ns/1ps
`include "memBus_cfg.svh"

module tb_memSubsystem;

	localparam int N_RANDOM = 40;
	localparam int N_FETCH  = 12;
	localparam int N_PAIR   = 12;
	localparam int N_FOLLOW = 4;
	localparam int N_RDONLY = 3;
	localparam int N_RANGE  = 4;

	// transactions, a pair counted once, plus reset and the idle window
	localparam int NUM_TESTS = N_RANDOM + N_FETCH + N_PAIR + 2 * N_FOLLOW
		+ 2 * N_RDONLY + N_RANGE + 2;
	localparam int CYCLE_LIMIT = NUM_TESTS * (2 * `MEM_RAM_LATENCY + 12) * 2;

	logic                   clock_cpu;
	logic                   reset;
	logic                   fetchReq;
	logic [`MEM_ADDR_W-1:0] fetchAddr;
	logic                   fetchDone;
	logic [`MEM_DATA_W-1:0] fetchData;
	logic                   fetchFault;
	logic [63:0]            fetchExc;
	logic                   dataReq;
	logic                   dataStore;
	logic [`MEM_ADDR_W-1:0] dataAddr;
	logic [`MEM_DATA_W-1:0] dataWData;
	logic                   dataDone;
	logic [`MEM_DATA_W-1:0] dataRData;
	logic                   dataFault;
	logic [63:0]            dataExc;

	logic [31:0] lfsrState;
	int          errorCount;
	int          checkCount;
	int          cycleCount;

	`include "memSubsystemModel.svh"

	memSubsystem memSubsystem_i
	(
		.clock_cpu  (clock_cpu),
		.reset      (reset),
		.fetchReq   (fetchReq),
		.fetchAddr  (fetchAddr),
		.fetchDone  (fetchDone),
		.fetchData  (fetchData),
		.fetchFault (fetchFault),
		.fetchExc   (fetchExc),
		.dataReq    (dataReq),
		.dataStore  (dataStore),
		.dataAddr   (dataAddr),
		.dataWData  (dataWData),
		.dataDone   (dataDone),
		.dataRData  (dataRData),
		.dataFault  (dataFault),
		.dataExc    (dataExc)
	);

	always #50 clock_cpu = ~clock_cpu;

	always @(posedge clock_cpu)
	begin
		cycleCount = cycleCount + 1;
		if (cycleCount >= CYCLE_LIMIT)
		begin
			$display("timeout: run exceeded %0d cycles without finishing", CYCLE_LIMIT);
			$display("sim failed");
			$finish;
		end
	end

	// Galois step per bit, the bit shifted out is the random bit
	function automatic logic [31:0] randBits(input int count);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < count; i++)
		begin
			value = {value[30:0], lfsrState[0]};
			if (lfsrState[0])
				lfsrState = (lfsrState >> 1) ^ 32'h80200003;
			else
				lfsrState = lfsrState >> 1;
		end
		return value;
	endfunction

	function automatic logic [`MEM_DATA_W-1:0] randData();
		logic [`MEM_DATA_W-1:0] value;
		for (int i = 0; i < `MEM_DATA_W / 32; i++)
			value[32*i +: 32] = randBits(32);
		return value;
	endfunction

	// kind 0 writable, 1 read-only, 2 any valid line, 3 out of range
	function automatic logic [`MEM_ADDR_W-1:0] randAddr(input int kind);
		logic [`MEM_ADDR_W-5:0] line;
		line = '0;
		case (kind)
			0:
			begin
				line[7:0] = 8'(randBits(8));
				if (line < `MEM_RO_LINES)
					line = line + `MEM_RO_LINES;
			end
			1: line[3:0] = 4'(randBits(4));
			2: line[7:0] = 8'(randBits(8));
			default:
			begin
				line[15:0] = 16'(randBits(16));
				line       = line + `MEM_RAM_LINES;
			end
		endcase
		return {line, 4'h0};
	endfunction

	task automatic checkEqual(input string name, input logic [127:0] expected,
		input logic [127:0] actual);
		checkCount++;
		if (expected !== actual)
		begin
			errorCount++;
			$display("Error %s: expected %0h, actual %0h", name, expected, actual);
		end
	endtask

	task automatic checkDataResult(input string name, input logic store,
		input logic [`MEM_ADDR_W-1:0] addr, input logic [`MEM_DATA_W-1:0] wdata);
		logic [7:0] code;
		code = faultCodeFor(addr, store);
		if (code != 8'h00)
		begin
			recordFault(excWordFor(addr, code));
			checkEqual($sformatf("%s dataFault", name), 1, dataFault);
		end
		else
		begin
			checkEqual($sformatf("%s dataFault", name), 0, dataFault);
			if (store)
				storeLine(addr, wdata);
			else
				checkEqual($sformatf("%s dataRData", name), loadLine(addr), dataRData);
		end
		checkEqual($sformatf("%s dataExc", name), expDataExc, dataExc);
		checkEqual($sformatf("%s fetchExc", name), expFetchExc, fetchExc);
	endtask

	task automatic checkFetchResult(input string name, input logic [`MEM_ADDR_W-1:0] addr);
		logic [7:0] code;
		code = faultCodeFor(addr, 1'b0);
		if (code != 8'h00)
		begin
			recordFault(excWordFor(addr, code));
			checkEqual($sformatf("%s fetchFault", name), 1, fetchFault);
		end
		else
		begin
			checkEqual($sformatf("%s fetchFault", name), 0, fetchFault);
			checkEqual($sformatf("%s fetchData", name), loadLine(addr), fetchData);
		end
		checkEqual($sformatf("%s dataExc", name), expDataExc, dataExc);
		checkEqual($sformatf("%s fetchExc", name), expFetchExc, fetchExc);
	endtask

	// one-cycle request strobe, then wait for done
	task automatic runData(input logic store, input logic [`MEM_ADDR_W-1:0] addr,
		input logic [`MEM_DATA_W-1:0] wdata);
		@(negedge clock_cpu);
		dataReq   = 1'b1;
		dataStore = store;
		dataAddr  = addr;
		dataWData = wdata;
		@(negedge clock_cpu);
		dataReq = 1'b0;
		while (!dataDone)
			@(negedge clock_cpu);
	endtask

	task automatic runFetch(input logic [`MEM_ADDR_W-1:0] addr);
		@(negedge clock_cpu);
		fetchReq  = 1'b1;
		fetchAddr = addr;
		@(negedge clock_cpu);
		fetchReq = 1'b0;
		while (!fetchDone)
			@(negedge clock_cpu);
	endtask

	// both ports at once, reports which one finished first
	task automatic runPair(input logic store, input logic [`MEM_ADDR_W-1:0] addr,
		input logic [`MEM_DATA_W-1:0] wdata, input logic [`MEM_ADDR_W-1:0] otherAddr,
		output logic fetchFirst);
		int dataDones;
		int fetchDones;
		dataDones  = 0;
		fetchDones = 0;
		fetchFirst = 1'b0;
		@(negedge clock_cpu);
		dataReq   = 1'b1;
		dataStore = store;
		dataAddr  = addr;
		dataWData = wdata;
		fetchReq  = 1'b1;
		fetchAddr = otherAddr;
		@(negedge clock_cpu);
		dataReq  = 1'b0;
		fetchReq = 1'b0;
		while ((dataDones == 0) || (fetchDones == 0))
		begin
			@(negedge clock_cpu);
			if (fetchDone && (dataDones == 0))
				fetchFirst = 1'b1;
			fetchDones += fetchDone;
			dataDones  += dataDone;
		end
		// quiet window to catch a repeated done
		repeat (4)
		begin
			@(negedge clock_cpu);
			fetchDones += fetchDone;
			dataDones  += dataDone;
		end
		checkEqual("pair data done count", 1, dataDones);
		checkEqual("pair fetch done count", 1, fetchDones);
	endtask

	initial
	begin
		logic [`MEM_ADDR_W-1:0] addr;
		logic [`MEM_ADDR_W-1:0] otherAddr;
		logic [`MEM_DATA_W-1:0] wdata;
		logic                   store;
		logic                   fetchFirst;
		int                     fetchFirstCount;

		clock_cpu       = 1'b0;
		reset           = 1'b1;
		fetchReq        = 1'b0;
		fetchAddr       = '0;
		dataReq         = 1'b0;
		dataStore       = 1'b0;
		dataAddr        = '0;
		dataWData       = '0;
		lfsrState       = 32'h21aa;
		errorCount      = 0;
		checkCount      = 0;
		cycleCount      = 0;
		fetchFirstCount = 0;
		resetShadow();

		repeat (10) @(negedge clock_cpu);
		reset = 1'b0;

		// nothing moves without a request
		repeat (20)
		begin
			@(negedge clock_cpu);
			checkEqual("idle fetchDone", 0, fetchDone);
			checkEqual("idle dataDone", 0, dataDone);
			checkEqual("idle fetchFault", 0, fetchFault);
			checkEqual("idle dataFault", 0, dataFault);
		end

		for (int i = 0; i < N_RANDOM; i++)
		begin
			store = randBits(1) != 0;
			addr  = randAddr(0);
			wdata = randData();
			runData(store, addr, wdata);
			checkDataResult($sformatf("random %0d", i), store, addr, wdata);
		end

		for (int i = 0; i < N_FETCH; i++)
		begin
			addr = randAddr(1);
			runFetch(addr);
			checkFetchResult($sformatf("fetch ro %0d", i), addr);
		end

		// completion order decides what a same-line fetch sees
		for (int i = 0; i < N_PAIR; i++)
		begin
			store = randBits(1) != 0;
			addr  = randAddr(0);
			wdata = randData();
			if (randBits(1) != 0)
				otherAddr = addr;
			else
				otherAddr = randAddr(2);
			// one spare cycle makes the pair spacing odd, so the strobe phase flips
			@(negedge clock_cpu);
			runPair(store, addr, wdata, otherAddr, fetchFirst);
			if (fetchFirst)
			begin
				fetchFirstCount++;
				checkFetchResult($sformatf("pair %0d fetch", i), otherAddr);
				checkDataResult($sformatf("pair %0d data", i), store, addr, wdata);
			end
			else
			begin
				checkDataResult($sformatf("pair %0d data", i), store, addr, wdata);
				checkFetchResult($sformatf("pair %0d fetch", i), otherAddr);
			end
		end

		// alternating strobe phase gives the fetch port every other pair
		checkEqual("pair fetch first count", N_PAIR / 2, fetchFirstCount);

		for (int i = 0; i < N_FOLLOW; i++)
		begin
			addr  = randAddr(0);
			wdata = randData();
			runData(1'b1, addr, wdata);
			checkDataResult($sformatf("follow %0d store", i), 1'b1, addr, wdata);
			runFetch(addr);
			checkFetchResult($sformatf("follow %0d load", i), addr);
		end

		for (int i = 0; i < N_RDONLY; i++)
		begin
			addr  = randAddr(1);
			wdata = randData();
			runData(1'b1, addr, wdata);
			checkDataResult($sformatf("rdonly %0d store", i), 1'b1, addr, wdata);
			runData(1'b0, addr, '0);
			checkDataResult($sformatf("rdonly %0d reload", i), 1'b0, addr, '0);
		end

		// alternate ports for out of range loads
		for (int i = 0; i < N_RANGE; i++)
		begin
			addr = randAddr(3);
			if ((i % 2) == 0)
			begin
				runData(1'b0, addr, '0);
				checkDataResult($sformatf("range %0d data", i), 1'b0, addr, '0);
			end
			else
			begin
				runFetch(addr);
				checkFetchResult($sformatf("range %0d fetch", i), addr);
			end
		end

		$display("checks %0d, errors %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

/* compile.f */
+incdir+rtl
+incdir+sim
rtl/memBusPkg.sv
rtl/memBusJoin.sv
rtl/memRequester.sv
rtl/memLineRam.sv
rtl/memSubsystem.sv
sim/tb_memSubsystem.sv

/* run.sh */
#!/bin/sh
# build with Verilator, run, then judge the log
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal -f compile.f --top-module tb_memSubsystem \
	|| { echo "verilator build error"; exit 1; }
./obj_dir/Vtb_memSubsystem > sim.log 2>&1
cat sim.log
grep -q "sim failed" sim.log && exit 1
grep -q "sim passed" sim.log || { echo "no result line in log"; exit 1; }
exit 0
